//--- Makefile
SIM = obj_dir/Vtb_cart_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cart_core -f list.f

# the status comes from the search for the pass line
run: compile
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- list.f
verilog/cart_pkg.sv
verilog/bus_pkg.sv
verilog/map_147.sv
verilog/cart_mem.sv
verilog/sst_engine.sv
verilog/cart_core.sv
tests/tb_cart_core.sv

//--- prg_rom.hex
// PRG ROM image, one byte per line, @ lines give the byte address
// bank b sits at b*$8000 with $A0+b at its first byte and $B0+b at its last
@00000
A0
@07FFF
B0
@08000
A1
@0FFFF
B1
@10000
A2
@17FFF
B2
@18000
A3
@1FFFF
B3

//--- tests/tb_cart_core.sv
`timescale 1ns/1ps

module tb_cart_core;

	// kinds of table row, one bus action each
	typedef enum logic [3:0] {
		op_cpu_wr,		// CPU write cycle
		op_cpu_rd,		// CPU read cycle with a data check
		op_ppu_wr,		// PPU write held over one m2 cycle
		op_ppu_rd,		// PPU read with a data check
		op_save,		// take a snapshot
		op_restore,		// put the snapshot back
		op_save_busy,	// snapshot while a second save and bank writes keep coming
		op_mir			// switch the mirroring bit of the cartridge config
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;	// write data, or the new bank for op_save_busy
		logic [7:0]  exp;	// expected read data or snapshot
	} row_t;

	logic              m2;
	logic              arst_n;
	logic [15:0]       cpu_addr;
	logic [7:0]        cpu_data;
	logic              cpu_rw;
	bus_pkg::cpu_bus_t cpu;
	bus_pkg::ppu_bus_t ppu;
	cart_pkg::cfg_t    cfg;
	logic              save;
	logic              restore;
	logic              cpu_oe;
	logic [7:0]        cpu_do;
	logic              ppu_oe;
	logic [7:0]        ppu_do;
	logic              busy;
	logic              done;
	logic [7:0]        snap_map;

	row_t       tbl[$];
	string      row_name[$];	// test names, same index as tbl
	logic [7:0] chr_sb [2**cart_pkg::CHR_AW];	// expected CHR RAM contents by CHR address
	integer     seed;
	int         cycles = 0;
	int         limit = 0;		// stays 0 until the table length is known

	assign cpu = {cpu_addr, cpu_data, cpu_rw, m2};	// the bus carries its own copy of m2

	cart_core dut0 (
		.m2       (m2),
		.arst_n   (arst_n),
		.cpu      (cpu),
		.ppu      (ppu),
		.cfg      (cfg),
		.save     (save),
		.restore  (restore),
		.cpu_oe   (cpu_oe),
		.cpu_do   (cpu_do),
		.ppu_oe   (ppu_oe),
		.ppu_do   (ppu_do),
		.busy     (busy),
		.done     (done),
		.snap_map (snap_map)
	);

	initial
	begin
		m2 = 1'b0;
		forever #50 m2 = ~m2;	// 100 ns m2 period
	end

	// hard stop if the table never finishes
	always @(posedge m2)
	begin
		cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout, run went past %0d m2 cycles", limit);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic abort_run(input string msg);
		$display("%0s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("mismatch %0s expected %02h actual %02h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("mismatch %0s expected %0b actual %0b", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_snap(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("mismatch %0s snapshot expected %02h actual %02h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("mismatch %0s cycles expected %0d actual %0d", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// every action starts 5 ns into a cycle from an idle bus
	task automatic next_drive_slot();
		@(posedge m2);
		#5;
		cpu_rw   = 1'b1;
		cpu_addr = 16'h0000;	// below $8000, nothing on the cartridge answers
		cpu_data = 8'h00;
		ppu      = '{addr: 14'h0000, data: 8'h00, oe: 1'b1, we: 1'b1};
		save     = 1'b0;
		restore  = 1'b0;
	endtask

	// marker bytes of the ROM image, bank index is register bits 7 and 2
	function automatic logic [7:0] prg_marker(input logic [7:0] reg_val, input logic [15:0] addr);
		logic [7:0] bank;
		bank = {6'd0, reg_val[7], reg_val[2]};
		if (addr[14:0] == 15'h0000)
			return 8'ha0 + bank;
		else
			return 8'hb0 + bank;
	endfunction

	task automatic add_row(input string name, input op_e op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] exp);
		row_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		tbl.push_back(r);
		row_name.push_back(name);
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [7:0]  d1;
		logic [7:0]  d2;
		logic [12:0] off;
		logic [7:0]  v;
		add_row("rst_lo", op_cpu_rd, 16'h8000, 8'h00, prg_marker(8'h00, 16'h8000));
		add_row("rst_hi", op_cpu_rd, 16'hffff, 8'h00, prg_marker(8'h00, 16'hffff));
		for (int b = 0; b < 4; b++)
		begin
			v = {b[1], 4'b0000, b[0], 2'b00};	// PRG bank bits only
			add_row($sformatf("prg%0d_sel", b), op_cpu_wr, cart_pkg::MAP_REG_ADDR, v, 8'h00);
			add_row($sformatf("prg%0d_lo", b), op_cpu_rd, 16'h8000, 8'h00, prg_marker(v, 16'h8000));
			add_row($sformatf("prg%0d_hi", b), op_cpu_rd, 16'hffff, 8'h00, prg_marker(v, 16'hffff));
		end
		// near misses of the register address must leave bank 3 in place
		add_row("miss_4103", op_cpu_wr, 16'h4103, 8'h00, 8'h00);
		add_row("miss_4002", op_cpu_wr, 16'h4002, 8'h00, 8'h00);
		add_row("miss_keep", op_cpu_rd, 16'h8000, 8'h00, prg_marker(8'h84, 16'h8000));
		// nametables sit above $2000, one page written at $2000 and the other elsewhere
		add_row("mir_h", op_mir, 16'h0000, 8'h00, 8'h00);
		add_row("nt_h_wr0", op_ppu_wr, 16'h2000, 8'h11, 8'h00);
		add_row("nt_h_wr1", op_ppu_wr, 16'h2800, 8'h22, 8'h00);
		add_row("nt_h_2400", op_ppu_rd, 16'h2400, 8'h00, 8'h11);	// same page as $2000
		add_row("nt_h_2c00", op_ppu_rd, 16'h2c00, 8'h00, 8'h22);
		add_row("mir_v", op_mir, 16'h0000, 8'h01, 8'h00);
		add_row("nt_v_wr0", op_ppu_wr, 16'h2000, 8'h33, 8'h00);
		add_row("nt_v_wr1", op_ppu_wr, 16'h2400, 8'h44, 8'h00);
		add_row("nt_v_2800", op_ppu_rd, 16'h2800, 8'h00, 8'h33);	// same page as $2000
		add_row("nt_v_2c00", op_ppu_rd, 16'h2c00, 8'h00, 8'h44);
		// one random offset in CHR banks 5 and 10 with two different bytes
		rnd = $random(seed);
		d1  = rnd[7:0];
		rnd = $random(seed);
		off = rnd[12:0];
		rnd = $random(seed);
		d2  = rnd[7:0];
		if (d2 == d1)
			d2 = ~d1;
		chr_sb[{4'd5, off}]  = d1;
		chr_sb[{4'd10, off}] = d2;
		add_row("chr_sel5", op_cpu_wr, cart_pkg::MAP_REG_ADDR, 8'h28, 8'h00);
		add_row("chr_wr5", op_ppu_wr, {3'b000, off}, d1, 8'h00);
		add_row("chr_sel10", op_cpu_wr, cart_pkg::MAP_REG_ADDR, 8'h50, 8'h00);
		add_row("chr_wr10", op_ppu_wr, {3'b000, off}, d2, 8'h00);
		add_row("chr_rd10", op_ppu_rd, {3'b000, off}, 8'h00, chr_sb[{4'd10, off}]);
		add_row("chr_back5", op_cpu_wr, cart_pkg::MAP_REG_ADDR, 8'h28, 8'h00);
		add_row("chr_rd5", op_ppu_rd, {3'b000, off}, 8'h00, chr_sb[{4'd5, off}]);
		// snapshot of bank 3, overwrite with bank 1, then restore
		add_row("sst_sel3", op_cpu_wr, cart_pkg::MAP_REG_ADDR, 8'h84, 8'h00);
		add_row("sst_save", op_save, 16'h0000, 8'h00, 8'h84);
		add_row("sst_sel1", op_cpu_wr, cart_pkg::MAP_REG_ADDR, 8'h04, 8'h00);
		add_row("sst_new", op_cpu_rd, 16'h8000, 8'h00, prg_marker(8'h04, 16'h8000));
		add_row("sst_restore", op_restore, 16'h0000, 8'h00, 8'h84);
		add_row("sst_back_lo", op_cpu_rd, 16'h8000, 8'h00, prg_marker(8'h84, 16'h8000));
		add_row("sst_back_hi", op_cpu_rd, 16'hffff, 8'h00, prg_marker(8'h84, 16'hffff));
		// the bank write only lands once the walk has let go of the register
		add_row("busy_save", op_save_busy, 16'h0000, 8'h80, 8'h84);
		add_row("busy_after", op_cpu_rd, 16'h8000, 8'h00, prg_marker(8'h80, 16'h8000));
	endtask

	task automatic run_snapshot(input row_t r, input string name);
		int   n;
		logic seen;
		next_drive_slot();
		if (r.op == op_restore)
			restore = 1'b1;
		else
			save = 1'b1;
		n    = 0;
		seen = 1'b0;
		while (!seen)
		begin
			next_drive_slot();
			if (r.op == op_save_busy)
			begin
				save     = 1'b1;	// has to be dropped by a busy engine
				cpu_rw   = 1'b0;
				cpu_addr = cart_pkg::MAP_REG_ADDR;
				cpu_data = r.data;
			end
			#40;
			n++;
			if (n == 1)
				check_flag({name, "_busy"}, 1'b1, busy);
			seen = done;
			if (!seen && n > 4 * cart_pkg::SST_SLOTS)
				abort_run({name, ": done never rose after the request"});
		end
		check_cycles({name, "_lat"}, cart_pkg::SST_SLOTS + 1, n);	// one per slot plus done
		next_drive_slot();
		#40;
		check_flag({name, "_idle"}, 1'b0, busy);
		check_flag({name, "_pulse"}, 1'b0, done);	// done lasts one cycle
		check_snap(name, r.exp, snap_map);
	endtask

	task automatic apply_row(input int i);
		row_t  r;
		string name;
		r    = tbl[i];
		name = row_name[i];
		case (r.op)
			op_cpu_wr:
			begin
				next_drive_slot();
				cpu_rw   = 1'b0;	// latched on the falling edge of m2
				cpu_addr = r.addr;
				cpu_data = r.data;
			end
			op_cpu_rd:
			begin
				next_drive_slot();
				cpu_addr = r.addr;
				#40;
				check_flag({name, "_oe"}, 1'b1, cpu_oe);
				check_byte(name, r.exp, cpu_do);
			end
			op_ppu_wr:
			begin
				next_drive_slot();
				ppu = '{addr: r.addr[13:0], data: r.data, oe: 1'b1, we: 1'b0};
			end
			op_ppu_rd:
			begin
				next_drive_slot();
				ppu = '{addr: r.addr[13:0], data: 8'h00, oe: 1'b0, we: 1'b1};
				#40;
				check_flag({name, "_oe"}, 1'b1, ppu_oe);
				check_byte(name, r.exp, ppu_do);
			end
			op_mir:
			begin
				next_drive_slot();
				cfg.mir_v = r.data[0];
			end
			default:
				run_snapshot(r, name);
		endcase
	endtask

	initial
	begin
		seed     = 54509;
		arst_n   = 1'b0;
		cpu_addr = 16'h0000;
		cpu_data = 8'h00;
		cpu_rw   = 1'b1;
		ppu      = '{addr: 14'h0000, data: 8'h00, oe: 1'b1, we: 1'b1};
		cfg      = '{map_idx: cart_pkg::MAP_IDX_147, mir_v: 1'b0, chr_ram: 1'b1};
		save     = 1'b0;
		restore  = 1'b0;
		build_table();
		limit = tbl.size() * 8 + 100;
		repeat (4) @(posedge m2);
		#5 arst_n = 1'b1;
		for (int i = 0; i < tbl.size(); i++)
			apply_row(i);
		next_drive_slot();	// let the last write settle
		$display("test passed");
		$finish;
	end

endmodule

//--- verilog/bus_pkg.sv
package bus_pkg;

	// CPU side of the cartridge edge
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;	// data written by the CPU
		logic        rw;	// high for a read cycle
		logic        m2;	// phi2 as seen on the edge connector
	} cpu_bus_t;

	// PPU side, the strobes are active low as on the real pins
	typedef struct packed {
		logic [13:0] addr;
		logic [7:0]  data;	// data written by the PPU
		logic        oe;	// read strobe, active low
		logic        we;	// write strobe, active low
	} ppu_bus_t;

	// one memory port as driven by a mapper, all strobes active high
	typedef struct packed {
		logic                        ce;
		logic                        oe;
		logic                        we;
		logic [cart_pkg::PRG_AW-1:0] addr;	// PRG and CHR share the same width
		logic [7:0]                  dati;	// write data into the memory
	} mem_ctrl_t;

	// save-state port between the engine and a mapper
	typedef struct packed {
		logic       act;	// snapshot in progress, CPU writes are blocked
		logic       we_reg;	// write dato into the slot at addr
		logic [7:0] addr;	// slot number
		logic [7:0] dato;	// value restored into the slot
	} sst_bus_t;

	// everything a mapper sees
	typedef struct packed {
		cpu_bus_t       cpu;
		ppu_bus_t       ppu;
		cart_pkg::cfg_t cfg;
		sst_bus_t       sst;
		logic [7:0]     prg_do;	// PRG read data
		logic [7:0]     chr_do;	// CHR read data
		logic [7:0]     srm_do;	// save RAM read data
	} map_in_t;

	// everything a mapper drives
	typedef struct packed {
		mem_ctrl_t  prg;
		mem_ctrl_t  chr;
		mem_ctrl_t  srm;
		logic       map_cpu_oe;	// cartridge drives the CPU data bus
		logic [7:0] map_cpu_do;
		logic       map_ppu_oe;	// cartridge drives the PPU data bus
		logic [7:0] map_ppu_do;
		logic       ciram_a10;	// nametable page select
		logic       ciram_ce;	// CIRAM enable, active low like the console pin
		logic       irq;		// active high request to the CPU
		logic [7:0] sst_di;		// slot value read back by the engine
	} map_out_t;

endpackage

//--- verilog/cart_core.sv
`timescale 1ns/1ps

module cart_core (
	input  logic              m2,
	input  logic              arst_n,
	input  bus_pkg::cpu_bus_t cpu,
	input  bus_pkg::ppu_bus_t ppu,
	input  cart_pkg::cfg_t    cfg,
	input  logic              save,
	input  logic              restore,
	output logic              cpu_oe,
	output logic [7:0]        cpu_do,
	output logic              ppu_oe,
	output logic [7:0]        ppu_do,
	output logic              busy,
	output logic              done,
	output logic [7:0]        snap_map
);

	bus_pkg::map_in_t  mai;
	bus_pkg::map_out_t mao;
	bus_pkg::sst_bus_t sst;
	logic [7:0]        prg_do;
	logic [7:0]        chr_do;
	logic [7:0]        ciram_do;

	// mapper input bundle, no save RAM is fitted so its data floats high
	assign mai = '{cpu: cpu, ppu: ppu, cfg: cfg, sst: sst,
		prg_do: prg_do, chr_do: chr_do, srm_do: 8'hff};

	map_147 u_map (
		.m2     (m2),
		.arst_n (arst_n),
		.mai    (mai),
		.mao    (mao)
	);

	cart_mem u_mem (
		.m2        (m2),
		.prg       (mao.prg),
		.chr       (mao.chr),
		.ciram_ce  (mao.ciram_ce),
		.ciram_a10 (mao.ciram_a10),
		.ppu       (ppu),
		.prg_do    (prg_do),
		.chr_do    (chr_do),
		.ciram_do  (ciram_do)
	);

	sst_engine u_sst (
		.m2       (m2),
		.arst_n   (arst_n),
		.save     (save),
		.restore  (restore),
		.sst_di   (mao.sst_di),
		.sst      (sst),
		.busy     (busy),
		.done     (done),
		.snap_map (snap_map)
	);

	assign cpu_oe = mao.map_cpu_oe;
	assign cpu_do = mao.map_cpu_do;

	// CIRAM lives in the console, its data reaches the bus beside the cartridge
	assign ppu_oe = mao.map_ppu_oe | (!mao.ciram_ce & !ppu.oe);
	assign ppu_do = ppu.addr[13] ? ciram_do : mao.map_ppu_do;

endmodule

//--- verilog/cart_mem.sv
`timescale 1ns/1ps

module cart_mem (
	input  logic               m2,
	input  bus_pkg::mem_ctrl_t prg,
	input  bus_pkg::mem_ctrl_t chr,
	input  logic               ciram_ce,	// active low
	input  logic               ciram_a10,
	input  bus_pkg::ppu_bus_t  ppu,
	output logic [7:0]         prg_do,
	output logic [7:0]         chr_do,
	output logic [7:0]         ciram_do
);

	logic [7:0]  prg_rom [2**cart_pkg::PRG_AW];	// 128 KB program ROM
	logic [7:0]  chr_ram [2**cart_pkg::CHR_AW];	// 128 KB pattern RAM
	logic [7:0]  ciram   [2048];					// the console's 2 KB nametable RAM
	logic [10:0] ciram_addr;

	// the ROM image is sparse, untouched bytes are whatever the simulator fills
	initial
	begin
		$readmemh("prg_rom.hex", prg_rom);
	end

	// mirroring only changes which page A10 of the RAM sees
	assign ciram_addr = {ciram_a10, ppu.addr[9:0]};

	// pattern RAM write, the PPU holds its strobe over the whole m2 cycle
	always_ff @(posedge m2)
	begin
		if (chr.ce && chr.we)
			chr_ram[chr.addr[cart_pkg::CHR_AW-1:0]] <= chr.dati;
	end

	// nametable write uses the raw PPU strobe, the mapper only routes A10 and CE
	always_ff @(posedge m2)
	begin
		if (!ciram_ce && !ppu.we)
			ciram[ciram_addr] <= ppu.data;
	end

	// asynchronous reads, a deselected part returns $FF
	always_comb
	begin
		prg_do = 8'hff;
		chr_do = 8'hff;
		if (prg.ce && prg.oe)
			prg_do = prg_rom[prg.addr[cart_pkg::PRG_AW-1:0]];
		if (chr.ce && chr.oe)
			chr_do = chr_ram[chr.addr[cart_pkg::CHR_AW-1:0]];
	end

	assign ciram_do = ciram[ciram_addr];	// the core picks this only for A13 high

	// the ROM has no write path, a write strobe here is a mapper bug
	a_prg_no_write : assert property (@(posedge m2) !(prg.ce && prg.we));

endmodule

//--- verilog/cart_pkg.sv
package cart_pkg;

	// cartridge configuration as set up by the loader before reset is released
	typedef struct packed {
		logic [7:0] map_idx;	// iNES mapper number
		logic       mir_v;		// 1 selects vertical mirroring, 0 horizontal
		logic       chr_ram;	// CHR is RAM and may be written by the PPU
	} cfg_t;

	// mapper identity and its single register
	localparam logic [7:0]  MAP_IDX_147  = 8'd147;
	localparam logic [15:0] MAP_REG_ADDR = 16'h4102;	// full decode, no mirrors

	// save-state slot map for this mapper
	localparam logic [7:0] SST_SLOT_MAP = 8'd0;		// bank register
	localparam logic [7:0] SST_SLOT_IDX = 8'd127;	// mapper index, read only
	localparam int         SST_SLOTS    = 2;		// slots walked per snapshot

	// both memories span 128 KB
	localparam int PRG_AW = 17;	// four 32 KB PRG banks
	localparam int CHR_AW = 17;	// sixteen 8 KB CHR banks

	// save-state engine sequencer
	typedef enum logic [1:0] {
		idle,			// waiting for save or restore
		save_slot,		// reading one slot from the mapper
		restore_slot,	// writing one slot back to the mapper
		finish			// one cycle to report done
	} sst_state_e;

endpackage

//--- verilog/map_147.sv
`timescale 1ns/1ps

module map_147 (
	input  logic              m2,
	input  logic              arst_n,
	input  bus_pkg::map_in_t  mai,
	output bus_pkg::map_out_t mao
);

	bus_pkg::cpu_bus_t  cpu;
	bus_pkg::ppu_bus_t  ppu;
	cart_pkg::cfg_t     cfg;
	bus_pkg::sst_bus_t  sst;
	bus_pkg::mem_ctrl_t prg;
	bus_pkg::mem_ctrl_t chr;
	bus_pkg::mem_ctrl_t srm;
	logic               ciram_ce;
	logic [7:0]         bank;	// the one latch of this board

	// unpack the incoming bundle so the decode below reads like the board
	assign cpu = mai.cpu;
	assign ppu = mai.ppu;
	assign cfg = mai.cfg;
	assign sst = mai.sst;

	// A13 low means pattern table, high means nametable in CIRAM
	assign ciram_ce = !ppu.addr[13];	// active low, so CIRAM is on when A13 is set

	always_comb
	begin
		// PRG ROM sits at $8000-$FFFF, bank from bits 7 and 2
		prg.ce   = cpu.addr[15];
		prg.oe   = cpu.rw;
		prg.we   = 1'b0;	// ROM
		prg.addr = {bank[7], bank[2], cpu.addr[14:0]};
		prg.dati = cpu.data;

		// CHR gets the low 8 KB of PPU space, bank from bits 6 to 3
		chr.ce   = !ppu.addr[13];
		chr.oe   = !ppu.oe;
		chr.we   = cfg.chr_ram & !ppu.we & !ppu.addr[13];	// only RAM boards take writes
		chr.addr = {bank[6:3], ppu.addr[12:0]};
		chr.dati = ppu.data;

		// there is no save RAM on this board
		srm.ce   = 1'b0;
		srm.oe   = 1'b0;
		srm.we   = 1'b0;
		srm.addr = {4'd0, cpu.addr[12:0]};
		srm.dati = cpu.data;
	end

	always_comb
	begin
		mao.prg = prg;
		mao.chr = chr;
		mao.srm = srm;

		// nothing internal is readable, so the CPU sees only memory
		mao.map_cpu_oe = (srm.ce & srm.oe) | (prg.ce & prg.oe);
		mao.map_cpu_do = srm.ce ? mai.srm_do : mai.prg_do;
		mao.map_ppu_oe = chr.ce & chr.oe;
		mao.map_ppu_do = mai.chr_do;

		// vertical mirroring pages on A10, horizontal on A11
		mao.ciram_a10 = cfg.mir_v ? ppu.addr[10] : ppu.addr[11];
		mao.ciram_ce  = ciram_ce;
		mao.irq       = 1'b0;

		// slot readback, unknown slots float high like an open bus
		if (sst.addr == cart_pkg::SST_SLOT_MAP)
			mao.sst_di = bank;
		else if (sst.addr == cart_pkg::SST_SLOT_IDX)
			mao.sst_di = cfg.map_idx;
		else
			mao.sst_di = 8'hff;
	end

	// the latch is clocked at the end of the CPU cycle when data is stable
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
			bank <= '0;
		else if (sst.act)
		begin
			// the save-state port owns the register for the whole snapshot
			if (sst.we_reg && sst.addr == cart_pkg::SST_SLOT_MAP)
				bank <= sst.dato;
		end
		else if (!cpu.rw && cpu.addr == cart_pkg::MAP_REG_ADDR)
			bank <= cpu.data;
	end

	// a stray save RAM enable would fight the console on $6000-$7FFF
	a_srm_off : assert property (@(posedge m2) disable iff (!arst_n) !mao.srm.ce);

	// pattern writes must never reach a ROM-based board
	a_chr_rom_ro : assert property (@(posedge m2) disable iff (!arst_n)
		!mai.cfg.chr_ram |-> !mao.chr.we);

endmodule

//--- verilog/sst_engine.sv
`timescale 1ns/1ps

module sst_engine (
	input  logic              m2,
	input  logic              arst_n,
	input  logic              save,		// one cycle request
	input  logic              restore,	// one cycle request
	input  logic [7:0]        sst_di,	// slot value from the mapper
	output bus_pkg::sst_bus_t sst,
	output logic              busy,
	output logic              done,
	output logic [7:0]        snap_map	// slot 0 of the stored snapshot
);

	cart_pkg::sst_state_e                     state;
	logic [$clog2(cart_pkg::SST_SLOTS)-1:0]   slot_idx;	// position in the slot walk
	logic [7:0]                               snap [cart_pkg::SST_SLOTS];
	logic                                     last_slot;

	assign last_slot = (slot_idx == cart_pkg::SST_SLOTS - 1);

	// the sequencer runs on the same edge the mapper latches on, so a restored
	// value lands in the register in the cycle its slot is presented
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= cart_pkg::idle;
			slot_idx <= '0;
			for (int i = 0; i < cart_pkg::SST_SLOTS; i++)
				snap[i] <= '0;
		end
		else
		begin
			case (state)
				cart_pkg::idle:
				begin
					slot_idx <= '0;
					if (save)	// save wins if both arrive together
						state <= cart_pkg::save_slot;
					else if (restore)
						state <= cart_pkg::restore_slot;
				end
				cart_pkg::save_slot:
				begin
					snap[slot_idx] <= sst_di;	// mapper answers combinationally
					if (last_slot)
						state <= cart_pkg::finish;
					else
						slot_idx <= slot_idx + 1'b1;
				end
				cart_pkg::restore_slot:
				begin
					if (last_slot)
						state <= cart_pkg::finish;
					else
						slot_idx <= slot_idx + 1'b1;
				end
				default:
					state <= cart_pkg::idle;	// finish lasts one cycle
			endcase
		end
	end

	// slot index to slot number, the walk visits the bank register then the id
	always_comb
	begin
		sst.act    = (state == cart_pkg::save_slot) || (state == cart_pkg::restore_slot);
		sst.we_reg = (state == cart_pkg::restore_slot);
		sst.addr   = (slot_idx == '0) ? cart_pkg::SST_SLOT_MAP : cart_pkg::SST_SLOT_IDX;
		sst.dato   = snap[slot_idx];	// the mapper drops the write to the id slot
	end

	assign busy     = (state != cart_pkg::idle);	// new requests are dropped while high
	assign done     = (state == cart_pkg::finish);
	assign snap_map = snap[0];

	// every restore write belongs to a walk that ends in done within the slot count
	a_restore_in_walk : assert property (@(negedge m2) disable iff (!arst_n)
		sst.we_reg |-> busy ##[1:cart_pkg::SST_SLOTS] done);

endmodule
